//--- Makefile
VERILATOR ?= verilator
TOP       ?= mbist_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -qF "All tests passed!" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/cell_address_counter.sv
`timescale 1ns/1ns

module cell_address_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  mbist_pkg::march_element_t element,
    output mbist_pkg::word_addr_t     word,
    output mbist_pkg::bit_index_t     bit_index,
    output logic                      access_valid,
    output logic                      last_cell
);
    import mbist_pkg::*;

    localparam word_addr_t TOP_WORD = word_addr_t'(WORD_COUNT - 1);
    localparam bit_index_t TOP_BIT  = bit_index_t'(WORD_WIDTH - 1);

    logic       loaded;
    logic       active;
    logic       down;
    word_addr_t end_word;
    bit_index_t end_bit;

    always_comb begin
        active   = (element != idle) && (element != finished);
        down     = element_descends(element);
        end_word = down ? '0 : TOP_WORD;
        end_bit  = down ? '0 : TOP_BIT;
    end

    assign access_valid = loaded;
    assign last_cell    = loaded && (word == end_word) && (bit_index == end_bit);

    always_ff @(posedge clk) begin
        if (reset || !start || !active || last_cell) begin
            loaded <= 1'b0;
        end else if (!loaded) begin
            loaded <= 1'b1;
        end
    end

    // Bits move fastest, then words
    always_ff @(posedge clk) begin
        if (active && !loaded) begin
            word      <= down ? TOP_WORD : '0;
            bit_index <= down ? TOP_BIT : '0;
        end else if (loaded && !last_cell) begin
            if (down) begin
                if (bit_index == '0) begin
                    word      <= word - 1'b1;
                    bit_index <= TOP_BIT;
                end else begin
                    bit_index <= bit_index - 1'b1;
                end
            end else begin
                if (bit_index == TOP_BIT) begin
                    word      <= word + 1'b1;
                    bit_index <= '0;
                end else begin
                    bit_index <= bit_index + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/faulty_bit_memory.sv
`timescale 1ns/1ns

module faulty_bit_memory (
    input  logic                   clk,
    input  logic                   reset,
    input  mbist_pkg::fault_mode_t fault_mode,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  mbist_pkg::word_addr_t  word,
    input  mbist_pkg::bit_index_t  bit_index,
    input  logic                   wr_data,
    output logic                   rd_data
);
    import mbist_pkg::*;

    logic [WORD_WIDTH-1:0] mem [WORD_COUNT];

    logic old_bit;
    logic stored_bit;
    logic couple_hit;

    assign old_bit = mem[word][bit_index];

    // Value that actually lands in the addressed cell
    always_comb begin
        stored_bit = wr_data;
        case (fault_mode)
            fault_stuck: begin
                if (word == STUCK0_WORD && bit_index == STUCK0_BIT) begin
                    stored_bit = 1'b0;
                end else if (word == STUCK1_WORD && bit_index == STUCK1_BIT) begin
                    stored_bit = 1'b1;
                end
            end
            fault_transition: begin
                if (word == RISE_BLOCK_WORD && bit_index == RISE_BLOCK_BIT) begin
                    stored_bit = old_bit & wr_data;
                end else if (word == FALL_BLOCK_WORD && bit_index == FALL_BLOCK_BIT) begin
                    stored_bit = old_bit | wr_data;
                end
            end
            default: begin
                stored_bit = wr_data;
            end
        endcase
    end

    // Rising write on the aggressor flips the victim unless enable holds 1
    assign couple_hit = (fault_mode == fault_coupling) && wr_data
                        && (word == COUPLE_WORD) && (bit_index == AGGRESSOR_BIT)
                        && !mem[COUPLE_WORD][ENABLE_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WORD_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[word][bit_index] <= stored_bit;
            if (couple_hit) begin
                mem[COUPLE_WORD][VICTIM_BIT] <= ~mem[COUPLE_WORD][VICTIM_BIT];
            end
        end
    end

    assign rd_data = rd_en ? old_bit : 1'b0;

endmodule

//--- rtl/march_sequencer.sv
`timescale 1ns/1ns

module march_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      access_valid,
    input  logic                      last_cell,
    output mbist_pkg::march_element_t element,
    output logic                      wr_en,
    output logic                      rd_en,
    output logic                      wr_data,
    output logic                      expected,
    output logic                      done
);
    import mbist_pkg::*;

    logic writes;

    always_ff @(posedge clk) begin
        if (reset || !start) begin
            element <= idle;
        end else if (element == idle || last_cell) begin
            element <= next_element(element);
        end
    end

    // Registered, so it follows entry into finished by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start && (element == finished);
        end
    end

    // Command decode for the current cell
    always_comb begin
        writes   = element_writes(element);
        wr_en    = access_valid && writes;
        rd_en    = access_valid && !writes;
        wr_data  = element_value(element);
        expected = element_value(element);
    end

endmodule

//--- rtl/mbist_pkg.sv
package mbist_pkg;

    localparam int WORD_COUNT = 8;
    localparam int WORD_WIDTH = 8;

    typedef logic [2:0] word_addr_t;
    typedef logic [2:0] bit_index_t;

    typedef enum logic [2:0] {
        idle,
        w0_up,
        r0_up,
        w1_up,
        r1_down,
        w0_down,
        r0_down,
        finished
    } march_element_t;

    typedef enum logic [1:0] {
        fault_stuck,
        fault_transition,
        fault_coupling,
        fault_none
    } fault_mode_t;

    // Stuck-at cells
    localparam word_addr_t STUCK0_WORD = 3'd1;
    localparam bit_index_t STUCK0_BIT  = 3'd2;
    localparam word_addr_t STUCK1_WORD = 3'd4;
    localparam bit_index_t STUCK1_BIT  = 3'd5;

    // Transition cells: one cannot rise, one cannot fall
    localparam word_addr_t RISE_BLOCK_WORD = 3'd5;
    localparam bit_index_t RISE_BLOCK_BIT  = 3'd3;
    localparam word_addr_t FALL_BLOCK_WORD = 3'd6;
    localparam bit_index_t FALL_BLOCK_BIT  = 3'd5;

    // Inverse coupling, all inside one word
    localparam word_addr_t COUPLE_WORD   = 3'd2;
    localparam bit_index_t AGGRESSOR_BIT = 3'd3;
    localparam bit_index_t VICTIM_BIT    = 3'd2;
    localparam bit_index_t ENABLE_BIT    = 3'd4;

    function automatic logic element_descends(march_element_t e);
        return (e == r1_down) || (e == w0_down) || (e == r0_down);
    endfunction

    function automatic logic element_writes(march_element_t e);
        return (e == w0_up) || (e == w1_up) || (e == w0_down);
    endfunction

    // Write data, or expected read data
    function automatic logic element_value(march_element_t e);
        return (e == w1_up) || (e == r1_down);
    endfunction

    function automatic march_element_t next_element(march_element_t e);
        march_element_t n;
        case (e)
            idle:    n = w0_up;
            w0_up:   n = r0_up;
            r0_up:   n = w1_up;
            w1_up:   n = r1_down;
            r1_down: n = w0_down;
            w0_down: n = r0_down;
            default: n = finished;
        endcase
        return n;
    endfunction

endpackage

//--- rtl/mbist_top.sv
`timescale 1ns/1ns

module mbist_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mbist_pkg::fault_mode_t fault_mode,
    output logic                   done,
    output logic                   fail,
    output mbist_pkg::word_addr_t  fail_word,
    output mbist_pkg::bit_index_t  fail_bit,
    output logic                   fail_seen
);
    import mbist_pkg::*;

    march_element_t element;
    word_addr_t     word;
    bit_index_t     bit_index;
    logic           access_valid;
    logic           last_cell;
    logic           wr_en;
    logic           rd_en;
    logic           wr_data;
    logic           rd_data;
    logic           expected;

    march_sequencer march_sequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .access_valid (access_valid),
        .last_cell    (last_cell),
        .element      (element),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_data      (wr_data),
        .expected     (expected),
        .done         (done)
    );

    cell_address_counter cell_address_counter_inst (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .element      (element),
        .word         (word),
        .bit_index    (bit_index),
        .access_valid (access_valid),
        .last_cell    (last_cell)
    );

    faulty_bit_memory faulty_bit_memory_inst (
        .clk        (clk),
        .reset      (reset),
        .fault_mode (fault_mode),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .word       (word),
        .bit_index  (bit_index),
        .wr_data    (wr_data),
        .rd_data    (rd_data)
    );

    response_checker response_checker_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .expected  (expected),
        .word      (word),
        .bit_index (bit_index),
        .fail      (fail),
        .fail_word (fail_word),
        .fail_bit  (fail_bit),
        .fail_seen (fail_seen)
    );

endmodule

//--- rtl/response_checker.sv
`timescale 1ns/1ns

module response_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  rd_en,
    input  logic                  rd_data,
    input  logic                  expected,
    input  mbist_pkg::word_addr_t word,
    input  mbist_pkg::bit_index_t bit_index,
    output logic                  fail,
    output mbist_pkg::word_addr_t fail_word,
    output mbist_pkg::bit_index_t fail_bit,
    output logic                  fail_seen
);

    logic mismatch;

    assign mismatch = start && rd_en && (rd_data != expected);

    always_ff @(posedge clk) begin
        if (reset) begin
            fail      <= 1'b0;
            fail_seen <= 1'b0;
        end else begin
            fail <= mismatch;
            // Each run starts clean
            if (!start) begin
                fail_seen <= 1'b0;
            end else if (mismatch) begin
                fail_seen <= 1'b1;
            end
        end
    end

    // Location of the failing cell
    always_ff @(posedge clk) begin
        if (mismatch) begin
            fail_word <= word;
            fail_bit  <= bit_index;
        end
    end

endmodule

//--- src.f
rtl/mbist_pkg.sv
rtl/march_sequencer.sv
rtl/cell_address_counter.sv
rtl/faulty_bit_memory.sv
rtl/response_checker.sv
rtl/mbist_top.sv
tb/mbist_tb.sv

//--- tb/mbist_tb.sv
`timescale 1ns/1ns

module mbist_tb;
    import mbist_pkg::*;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_EDGES    = 391;
    localparam int RUN_TIMEOUT  = 500;
    localparam int ABORT_CYCLES = 100;

    logic        clk;
    logic        reset;
    logic        start;
    fault_mode_t fault_mode;
    logic        done;
    logic        fail;
    word_addr_t  fail_word;
    bit_index_t  fail_bit;
    logic        fail_seen;

    int   error_count;
    int   tests_run;
    int   tests_failed;
    logic timed_out;
    int   done_edges;
    logic seen_during_run;
    int   got_words[$];
    int   got_bits[$];
    int   exp_words[$];
    int   exp_bits[$];

    mbist_top mbist_top_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .fault_mode (fault_mode),
        .done       (done),
        .fail       (fail),
        .fail_word  (fail_word),
        .fail_bit   (fail_bit),
        .fail_seen  (fail_seen)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            $display("[ERROR] %0t ns: %s expected %0b, got %0b", $time, name, want, got);
            error_count++;
        end
    endtask

    task automatic check_value(input string name, input int got, input int want);
        assert (got == want) else begin
            $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, want, got);
            error_count++;
        end
    endtask

    task automatic check_quiet_outputs();
        check_bit("done", done, 1'b0);
        check_bit("fail", fail, 1'b0);
        check_bit("fail_seen", fail_seen, 1'b0);
    endtask

    // Outputs stay low during reset and on the cycle after it
    task automatic drive_reset(input fault_mode_t mode);
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
        // Dropping start alone clears the sticky flag of the last run
        check_bit("fail_seen", fail_seen, 1'b0);
        reset      = 1'b1;
        fault_mode = mode;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_quiet_outputs();
        end
        reset = 1'b0;
        @(negedge clk);
        check_quiet_outputs();
    endtask

    // Raise start and collect fail locations until done
    task automatic run_march();
        int cycles;
        cycles          = 0;
        seen_during_run = 1'b0;
        got_words.delete();
        got_bits.delete();
        @(negedge clk);
        start = 1'b1;
        while (!done && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (fail) begin
                got_words.push_back(int'(fail_word));
                got_bits.push_back(int'(fail_bit));
            end
            seen_during_run = seen_during_run | fail_seen;
            if (!done && cycles >= RUN_TIMEOUT) begin
                $display("Timeout: done did not rise within %0d cycles of start", RUN_TIMEOUT);
                timed_out = 1'b1;
            end
        end
        // First counted edge is the one that samples start
        done_edges = cycles - 1;
    endtask

    task automatic add_expected(input int word_idx, input int bit_idx);
        exp_words.push_back(word_idx);
        exp_bits.push_back(bit_idx);
    endtask

    task automatic load_expected(input fault_mode_t mode);
        exp_words.delete();
        exp_bits.delete();
        case (mode)
            fault_stuck: begin
                // (4,5) held at 1 fails r0_up and r0_down; (1,2) held at 0 fails r1_down
                add_expected(4, 5);
                add_expected(1, 2);
                add_expected(4, 5);
            end
            fault_transition: begin
                // (5,3) never rises, (6,5) never falls
                add_expected(5, 3);
                add_expected(6, 5);
            end
            fault_coupling: begin
                // w1_up reaches bit 3 before bit 4, so victim flips back to 0
                add_expected(2, 2);
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_run();
        int count;
        count = (got_words.size() < exp_words.size()) ? got_words.size() : exp_words.size();
        check_value("done edges", done_edges, RUN_EDGES);
        check_value("fail count", got_words.size(), exp_words.size());
        for (int i = 0; i < count; i++) begin
            check_value($sformatf("fail_word[%0d]", i), got_words[i], exp_words[i]);
            check_value($sformatf("fail_bit[%0d]", i), got_bits[i], exp_bits[i]);
        end
        check_bit("fail_seen", fail_seen, logic'(exp_words.size() != 0));
        check_bit("fail_seen during run", seen_during_run, logic'(exp_words.size() != 0));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before && !timed_out) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end
    endtask

    task automatic run_reset_test();
        int errors_before;
        errors_before = error_count;
        drive_reset(fault_none);
        report_test("reset defaults", errors_before);
    endtask

    task automatic run_fault_test(input string name, input fault_mode_t mode);
        int errors_before;
        errors_before = error_count;
        drive_reset(mode);
        load_expected(mode);
        run_march();
        if (!timed_out) begin
            check_run();
        end
        report_test(name, errors_before);
    endtask

    task automatic run_abort_test();
        int errors_before;
        errors_before = error_count;
        drive_reset(fault_none);
        @(negedge clk);
        start = 1'b1;
        repeat (ABORT_CYCLES) begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
        end
        start = 1'b0;
        @(negedge clk);
        check_bit("done", done, 1'b0);
        check_bit("fail_seen", fail_seen, 1'b0);
        load_expected(fault_none);
        run_march();
        if (!timed_out) begin
            check_run();
        end
        report_test("abort and restart", errors_before);
    endtask

    task automatic run_all_tests();
        run_reset_test();
        run_fault_test("fault-free run", fault_none);
        if (timed_out) return;
        run_fault_test("stuck-at faults", fault_stuck);
        if (timed_out) return;
        run_fault_test("transition faults", fault_transition);
        if (timed_out) return;
        run_fault_test("coupling fault", fault_coupling);
        if (timed_out) return;
        run_abort_test();
    endtask

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        fault_mode   = fault_none;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        run_all_tests();
        $display("Tests run: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_failed, error_count);
        if (timed_out || error_count != 0 || tests_failed != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule
